// ==== src/mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

  localparam int mem_word_bits = 64;  // Bus data word and line width
  localparam int mem_tag_bits  = 4;   // Transaction tag width

  // Number of tag values; tag 0 is reserved for "no transaction"
  localparam int mem_tag_count = 1 << mem_tag_bits;

  typedef enum logic [1:0] {
    bus_none  = 2'd0,  // Idle
    bus_load  = 2'd1,  // Line read
    bus_store = 2'd2   // Line write
  } mem_command_t;

  typedef logic [mem_tag_bits-1:0]  mem_tag_t;   // Zero means none
  typedef logic [mem_word_bits-1:0] mem_word_t;  // One word, one line
  typedef logic [63:0]              mem_addr_t;  // Byte address

endpackage

`default_nettype wire

// ==== src/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  // Address split for a line address
  //   [31 : 3+idx]  stored tag
  //   [3+idx-1 : 3] line index
  //   [2 : 0]       byte offset inside the line

  localparam int line_offset_bits = 3;                      // Byte offset width
  localparam int line_bytes       = 1 << line_offset_bits;  // Bytes per line

  localparam int icache_idx_bits_default = 5;  // 32 lines

  // Tag and index together span address bits 31 down to 3
  localparam int icache_tag_bits_default = 32 - line_offset_bits
                                           - icache_idx_bits_default;

endpackage

`default_nettype wire

// ==== src/icache_fill_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface icache_fill_if
  import mem_bus_pkg::*, icache_pkg::*;
#(
  parameter int idx_bits = icache_idx_bits_default,
  parameter int tag_bits = icache_tag_bits_default
) ();

  logic                write_enable;  // Write at this rising edge
  logic [idx_bits-1:0] write_index;   // Line to overwrite
  logic [tag_bits-1:0] write_tag;     // Tag stored with the line
  mem_word_t           write_data;    // Returned line

  modport ctrl  (output write_enable, write_index, write_tag, write_data);
  modport lines (input  write_enable, write_index, write_tag, write_data);

endinterface

`default_nettype wire

// ==== src/icache_lookup_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface icache_lookup_if
  import mem_bus_pkg::*, icache_pkg::*;
#(
  parameter int idx_bits = icache_idx_bits_default,
  parameter int tag_bits = icache_tag_bits_default
) ();

  logic [idx_bits-1:0] lookup_index;  // From the fetch address
  logic [tag_bits-1:0] lookup_tag;
  mem_word_t           hit_data;      // Combinational result
  logic                hit_valid;

  modport ctrl  (output lookup_index, lookup_tag, input  hit_data, hit_valid);
  modport lines (input  lookup_index, lookup_tag, output hit_data, hit_valid);

endinterface

`default_nettype wire

// ==== src/icache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl
  import mem_bus_pkg::*, icache_pkg::*;
#(
  parameter int idx_bits = icache_idx_bits_default,
  parameter int tag_bits = icache_tag_bits_default
) (
  input  logic                  clock,
  input  logic                  reset,
  input  mem_tag_t              mem_response,
  input  mem_word_t             mem_data,
  input  mem_tag_t              mem_tag,
  input  mem_addr_t             fetch_addr,
  input  logic                  stall,
  output mem_command_t          mem_command,
  output mem_addr_t             mem_addr,
  output mem_word_t             fetch_data,
  output logic                  fetch_valid,
  icache_fill_if.ctrl           fill,
  icache_lookup_if.ctrl         lookup
);

  localparam int tag_lsb = line_offset_bits + idx_bits;

  // Outstanding request table, indexed by transaction tag
  mem_addr_t                  req_addr [mem_tag_count];
  logic [mem_tag_count-1:0]   req_valid;

  mem_addr_t prefetch_ptr;   // Next line to request
  mem_addr_t next_ptr;
  mem_addr_t fetch_line;     // Fetch address with offset cleared
  mem_addr_t ret_addr;       // Line recorded for the current return
  logic      ret_valid;
  logic      forward;
  logic      outstanding;
  logic      redirect;

  assign fetch_line = {fetch_addr[63:line_offset_bits], {line_offset_bits{1'b0}}};

  assign lookup.lookup_index = fetch_addr[line_offset_bits +: idx_bits];
  assign lookup.lookup_tag   = fetch_addr[tag_lsb +: tag_bits];

  // Is the fetch line already requested? Tag 0 never holds an entry
  always_comb
  begin
    outstanding = 1'b0;
    for (int i = 1; i < mem_tag_count; i++)
    begin
      if (req_valid[i] && (req_addr[i] == fetch_line))
        outstanding = 1'b1;
    end
  end

  assign ret_valid = (mem_tag != '0) && req_valid[mem_tag];  // Return we asked for
  assign ret_addr  = req_addr[mem_tag];
  assign forward   = ret_valid && (ret_addr == fetch_line);  // Bypass the line store

  assign fetch_data  = forward ? mem_data : lookup.hit_data;
  assign fetch_valid = forward | lookup.hit_valid;

  // Jump the prefetch stream when nothing will deliver the fetch line
  assign redirect = !outstanding && !lookup.hit_valid && !forward;
  assign next_ptr = redirect ? fetch_line : prefetch_ptr + mem_addr_t'(line_bytes);

  assign mem_command = reset ? bus_none : bus_load;  // Always loading out of reset
  assign mem_addr    = prefetch_ptr;

  // Every tracked return is written into the line store
  assign fill.write_enable = ret_valid;
  assign fill.write_index  = ret_addr[line_offset_bits +: idx_bits];
  assign fill.write_tag    = ret_addr[tag_lsb +: tag_bits];
  assign fill.write_data   = mem_data;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      prefetch_ptr <= '0;
      req_valid    <= '0;
    end
    else
    begin
      if (ret_valid)
        req_valid[mem_tag] <= 1'b0;  // Entry retires on its return
      if ((mem_response != '0) && !stall)
      begin
        prefetch_ptr            <= next_ptr;
        req_valid[mem_response] <= 1'b1;  // Set wins over a same-cycle clear
      end
    end
  end

  always_ff @(posedge clock)
  begin
    if ((mem_response != '0) && !stall)
      req_addr[mem_response] <= prefetch_ptr;  // Address the memory just accepted
  end

endmodule

`default_nettype wire

// ==== src/icache_lines.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_lines
  import mem_bus_pkg::*, icache_pkg::*;
#(
  parameter int idx_bits = icache_idx_bits_default,
  parameter int tag_bits = icache_tag_bits_default
) (
  input  logic            clock,
  input  logic            reset,
  icache_fill_if.lines    fill,
  icache_lookup_if.lines  lookup
);

  localparam int line_count = 1 << idx_bits;

  mem_word_t              line_data [line_count];
  logic [tag_bits-1:0]    line_tag  [line_count];
  logic [line_count-1:0]  line_valid;

  // Direct-mapped lookup, one candidate line per index
  assign lookup.hit_data  = line_data[lookup.lookup_index];
  assign lookup.hit_valid = line_valid[lookup.lookup_index]
                            && (line_tag[lookup.lookup_index] == lookup.lookup_tag);

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      line_valid <= '0;  // Cache starts empty
    end
    else if (fill.write_enable)
    begin
      line_valid[fill.write_index] <= 1'b1;
    end
  end

  always_ff @(posedge clock)
  begin
    if (fill.write_enable)
    begin
      line_data[fill.write_index] <= fill.write_data;
      line_tag[fill.write_index]  <= fill.write_tag;  // Old line is simply replaced
    end
  end

endmodule

`default_nettype wire

// ==== src/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top
  import mem_bus_pkg::*, icache_pkg::*;
#(
  parameter int idx_bits = icache_idx_bits_default,
  parameter int tag_bits = icache_tag_bits_default
) (
  input  logic          clock,
  input  logic          reset,

  // Instruction memory bus
  output mem_command_t  mem_command,
  output mem_addr_t     mem_addr,
  input  mem_tag_t      mem_response,  // Nonzero grants mem_addr under this tag
  input  mem_word_t     mem_data,
  input  mem_tag_t      mem_tag,       // Marks the return cycle

  // Fetch side
  input  mem_addr_t     fetch_addr,
  input  logic          stall,
  output mem_word_t     fetch_data,
  output logic          fetch_valid    // Same cycle as fetch_addr
);

  icache_fill_if #(
    .idx_bits (idx_bits),
    .tag_bits (tag_bits)
  ) fill ();

  icache_lookup_if #(
    .idx_bits (idx_bits),
    .tag_bits (tag_bits)
  ) lookup ();

  icache_ctrl #(
    .idx_bits (idx_bits),
    .tag_bits (tag_bits)
  ) ctrl_i (
    .clock        (clock),
    .reset        (reset),
    .mem_response (mem_response),
    .mem_data     (mem_data),
    .mem_tag      (mem_tag),
    .fetch_addr   (fetch_addr),
    .stall        (stall),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .fetch_data   (fetch_data),
    .fetch_valid  (fetch_valid),
    .fill         (fill.ctrl),
    .lookup       (lookup.ctrl)
  );

  icache_lines #(
    .idx_bits (idx_bits),
    .tag_bits (tag_bits)
  ) lines_i (
    .clock  (clock),
    .reset  (reset),
    .fill   (fill.lines),
    .lookup (lookup.lines)
  );

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int half_period_ns = 2,
  parameter int reset_cycles   = 16
) (
  output logic clock,
  output logic reset
);

  initial
  begin
    clock = 1'b0;
    forever #(half_period_ns) clock = ~clock;
  end

  // Reset drops 1 ns after its last edge, like the other driven inputs
  initial
  begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    #1;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== tests/imem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module imem_model
  import mem_bus_pkg::*;
#(
  parameter int grant_percent = 60,  // Chance of a grant in a cycle
  parameter int min_latency   = 2,
  parameter int max_latency   = 9
) (
  input  logic         clock,
  input  logic         reset,
  input  mem_command_t mem_command,
  input  mem_addr_t    mem_addr,
  output mem_tag_t     mem_response,
  output mem_word_t    mem_data,
  output mem_tag_t     mem_tag
);

  mem_addr_t                tag_addr [mem_tag_count];
  int                       tag_due  [mem_tag_count];  // Cycle of the return
  logic [mem_tag_count-1:0] tag_busy;
  int                       cycle;

  // Memory contents: line address next to its inverse
  function automatic mem_word_t line_contents(input mem_addr_t line);
    return {line[31:0], ~line[31:0]};
  endfunction

  initial
  begin
    int pick;
    int best_due;
    mem_response = '0;
    mem_data     = '0;
    mem_tag      = '0;
    tag_busy     = '0;
    cycle        = 0;
    forever
    begin
      @(posedge clock);
      cycle = cycle + 1;
      if (reset)
        tag_busy = '0;
      else
      begin
        if (mem_tag != '0)
          tag_busy[mem_tag] = 1'b0;  // Return done, tag free again
        if ((mem_response != '0) && (mem_command == bus_load))
        begin
          tag_busy[mem_response] = 1'b1;
          tag_addr[mem_response] = mem_addr;
          tag_due[mem_response]  = cycle - 1 + int'($urandom_range(min_latency, max_latency));
        end
      end
      #1;
      pick     = 0;
      best_due = 0;
      for (int t = 1; t < mem_tag_count; t++)
      begin
        if (tag_busy[t] && (tag_due[t] <= cycle) && ((pick == 0) || (tag_due[t] < best_due)))
        begin
          pick     = t;
          best_due = tag_due[t];
        end
      end
      mem_tag      = mem_tag_t'(pick);  // Oldest due return, one per cycle
      mem_data     = (pick != 0) ? line_contents(tag_addr[pick]) : '0;
      mem_response = '0;
      if ($urandom_range(0, 99) < grant_percent)
      begin
        for (int t = mem_tag_count - 1; t >= 1; t--)
        begin
          if (!tag_busy[t])
            mem_response = mem_tag_t'(t);  // Lowest free tag
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/icache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tb
  import mem_bus_pkg::*, icache_pkg::*;
();

  localparam int cycle_ns       = 4;
  localparam int max_cycles     = 4000;
  localparam int watchdog_ns    = max_cycles * cycle_ns + 20 * cycle_ns;
  localparam int max_fetch_wait = 64;  // Cycles a fetch may go unserved
  localparam int drain_cycles   = 16;  // Longer than any return latency
  localparam mem_addr_t branch_base = 64'h4000;
  localparam mem_addr_t stall_base  = 64'h6000;
  localparam mem_addr_t loop_base   = 64'h8000;

  logic         clock;
  logic         reset;
  mem_command_t mem_command;
  mem_addr_t    mem_addr;
  mem_tag_t     mem_response;
  mem_word_t    mem_data;
  mem_tag_t     mem_tag;
  mem_addr_t    fetch_addr;
  logic         stall;
  mem_word_t    fetch_data;
  logic         fetch_valid;

  logic         rewalk;             // Second walk of the loop
  logic         have_accept;
  mem_addr_t    last_accept_addr;
  mem_addr_t    last_accept_fetch;  // Fetch line at that accept
  mem_addr_t    prev_mem_addr;
  logic         prev_stall;
  int           wait_cycles;
  int           accept_count;
  int           fetch_count    = 0;
  int           command_errors = 0;
  int           data_errors    = 0;
  int           accept_errors  = 0;
  int           align_errors   = 0;
  int           stall_errors   = 0;
  int           wait_errors    = 0;
  int           loop_errors    = 0;

  tb_clock_gen #(.half_period_ns (cycle_ns / 2), .reset_cycles (16)) clock_gen_i (
    .clock (clock), .reset (reset)
  );

  icache_top dut_i (
    .clock        (clock),        .reset      (reset),
    .mem_command  (mem_command),  .mem_addr   (mem_addr),
    .mem_response (mem_response), .mem_data   (mem_data),
    .mem_tag      (mem_tag),      .fetch_addr (fetch_addr),
    .stall        (stall),        .fetch_data (fetch_data),
    .fetch_valid  (fetch_valid)
  );

  imem_model imem_i (
    .clock        (clock),        .reset    (reset),
    .mem_command  (mem_command),  .mem_addr (mem_addr),
    .mem_response (mem_response), .mem_data (mem_data),
    .mem_tag      (mem_tag)
  );

  function automatic mem_addr_t line_of(input mem_addr_t addr);
    return {addr[63:line_offset_bits], {line_offset_bits{1'b0}}};
  endfunction

  function automatic mem_word_t expected_line_data(input mem_addr_t addr);
    mem_addr_t line;
    line = line_of(addr);
    return {line[31:0], ~line[31:0]};
  endfunction

  function automatic mem_addr_t with_offset(input mem_addr_t line);
    return line + mem_addr_t'($urandom_range(0, line_bytes - 1));
  endfunction

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  // Hold the address until the fetch side serves it
  task automatic fetch_until_valid(input mem_addr_t addr);
    fetch_addr  = addr;
    fetch_count = fetch_count + 1;
    @(negedge clock);
    while (!fetch_valid)
    begin
      next_cycle();
      @(negedge clock);
    end
    next_cycle();
  endtask

  task automatic hold_stall(input int cycles);
    stall = 1'b1;
    repeat (cycles) next_cycle();
    stall = 1'b0;
  endtask

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      have_accept  <= 1'b0;
      prev_stall   <= 1'b0;
      wait_cycles  <= 0;
      accept_count <= 0;
    end
    else
    begin
      prev_stall    <= stall;
      prev_mem_addr <= mem_addr;
      wait_cycles   <= fetch_valid ? 0 : wait_cycles + 1;
      if ((mem_response != '0) && !stall)
      begin
        have_accept       <= 1'b1;
        last_accept_addr  <= mem_addr;
        last_accept_fetch <= line_of(fetch_addr);
        accept_count      <= accept_count + 1;
      end
    end
  end

  command_check: assert property (@(posedge clock) mem_command == (reset ? bus_none : bus_load))
    else
    begin
      command_errors++;
      $display("[FAIL] %0t mem_command expected %0d got %0d", $time,
               $sampled(reset) ? bus_none : bus_load, $sampled(mem_command));
    end

  data_check: assert property (@(posedge clock) disable iff (reset)
    fetch_valid |-> (fetch_data == expected_line_data(fetch_addr)))
    else
    begin
      data_errors++;
      $display("[FAIL] %0t fetch_data expected %h got %h", $time,
               expected_line_data($sampled(fetch_addr)), $sampled(fetch_data));
    end

  // Next accepted line follows the last one or jumps to the fetch line
  accept_check: assert property (@(posedge clock) disable iff (reset)
    ((mem_response != '0) && !stall && have_accept) |->
      ((mem_addr == last_accept_addr + mem_addr_t'(line_bytes)) ||
       (mem_addr == last_accept_fetch)))
    else
    begin
      accept_errors++;
      $display("[FAIL] %0t mem_addr expected %h or %h got %h", $time,
               $sampled(last_accept_addr) + mem_addr_t'(line_bytes),
               $sampled(last_accept_fetch), $sampled(mem_addr));
    end

  align_check: assert property (@(posedge clock) disable iff (reset)
    ((mem_response != '0) && !stall) |-> (mem_addr[line_offset_bits-1:0] == '0))
    else
    begin
      align_errors++;
      $display("[FAIL] %0t mem_addr offset expected 0 got %h", $time, $sampled(mem_addr));
    end

  stall_check: assert property (@(posedge clock) disable iff (reset)
    prev_stall |-> (mem_addr == prev_mem_addr))
    else
    begin
      stall_errors++;
      $display("[FAIL] %0t mem_addr expected %h got %h", $time,
               $sampled(prev_mem_addr), $sampled(mem_addr));
    end

  wait_check: assert property (@(posedge clock) disable iff (reset)
    wait_cycles < max_fetch_wait)
    else
    begin
      wait_errors++;
      $display("%0t fetch of %h not served within %0d cycles", $time,
               $sampled(fetch_addr), max_fetch_wait);
    end

  loop_check: assert property (@(posedge clock) disable iff (reset) rewalk |-> fetch_valid)
    else
    begin
      loop_errors++;
      $display("[FAIL] %0t fetch_valid expected 1 got 0 at %h", $time, $sampled(fetch_addr));
    end

  initial
  begin
    mem_addr_t line;
    int        walk;
    int        total;
    void'($urandom(32'h25d2));
    fetch_addr = '0;
    stall      = 1'b0;
    rewalk     = 1'b0;
    @(negedge reset);
    next_cycle();

    for (int i = 0; i < 200; i++)
      fetch_until_valid(with_offset(mem_addr_t'(i * line_bytes)));

    // Branches into a region twice the cache size, each with a short walk
    repeat (40)
    begin
      line = branch_base + mem_addr_t'($urandom_range(0, 63) * line_bytes);
      walk = $urandom_range(1, 4);
      for (int i = 0; i < walk; i++)
        fetch_until_valid(with_offset(line + mem_addr_t'(i * line_bytes)));
    end

    for (int i = 0; i < 80; i++)
    begin
      fetch_addr = with_offset(stall_base + mem_addr_t'(i * line_bytes));
      if ($urandom_range(0, 3) == 0)
        hold_stall($urandom_range(2, 8));
      fetch_until_valid(fetch_addr);
    end

    // Pointer frozen while older returns drain, so nothing evicts the loop
    hold_stall(drain_cycles);
    fetch_until_valid(loop_base);
    hold_stall(drain_cycles);
    for (int i = 1; i < 16; i++)
      fetch_until_valid(with_offset(loop_base + mem_addr_t'(i * line_bytes)));
    stall = 1'b1;
    repeat (drain_cycles) next_cycle();
    rewalk = 1'b1;
    for (int i = 0; i < 16; i++)
    begin
      fetch_addr  = with_offset(loop_base + mem_addr_t'(i * line_bytes));
      fetch_count = fetch_count + 1;
      next_cycle();
    end
    rewalk = 1'b0;
    stall  = 1'b0;
    repeat (4) next_cycle();

    total = command_errors + data_errors + accept_errors + align_errors
            + stall_errors + wait_errors + loop_errors;
    $display("Summary: %0d fetches, %0d accepts, %0d errors (command %0d data %0d accept %0d %s",
             fetch_count, accept_count, total, command_errors, data_errors, accept_errors,
             $sformatf("align %0d stall %0d wait %0d loop %0d)", align_errors, stall_errors,
                       wait_errors, loop_errors));
    if (total == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  initial
  begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns before the stimulus finished", watchdog_ns);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== icache_top.f ====
src/mem_bus_pkg.sv
src/icache_pkg.sv
src/icache_fill_if.sv
src/icache_lookup_if.sv
src/icache_ctrl.sv
src/icache_lines.sv
src/icache_top.sv
tests/tb_clock_gen.sv
tests/imem_model.sv
tests/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module icache_tb -f icache_top.f -o icache_sim

result=$(./obj_dir/icache_sim)
printf '%s\n' "$result"
printf '%s\n' "$result" | grep -qx 'No errors'
